// ==== rtl/axis_mux_cfg.svh ====
// ---------------------------------------
// Stream mux configuration
// Default channel count and beat field
// widths for the streaming multiplexer
// ---------------------------------------

`ifndef AXIS_MUX_CFG_SVH
`define AXIS_MUX_CFG_SVH

// Input channels, legal range 1 to 4
`define AXM_NUM_CH 4

// Beat data width in bits, a whole number of bytes
`define AXM_DATA_W 32

// Vendor side-band field
`define AXM_USER_W 4

`endif

// ==== rtl/axis_mux_pkg.sv ====
`default_nettype none

`include "axis_mux_cfg.svh"

// ---------------------------------------
// Stream mux types
// Beat struct and arbiter lock state
// ---------------------------------------

package axis_mux_pkg;

   localparam int KEEP_W = `AXM_DATA_W / 8;

   // One stream beat, all fields move as a unit
   typedef struct packed {
      logic [`AXM_DATA_W-1:0] data;
      logic [KEEP_W-1:0]      keep;
      logic                   last;
      logic [`AXM_USER_W-1:0] user;
   } axis_beat_t;

   // Arbiter lock state
   typedef enum logic {
      ARB_IDLE   = 1'b0,
      ARB_LOCKED = 1'b1
   } arb_state_t;

endpackage

`default_nettype wire

// ==== rtl/axis_skid_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

// ---------------------------------------
// Stream register slice
// Main entry plus skid entry, so s_ready
// comes from a flop at full throughput
// ---------------------------------------

module axis_skid_reg (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     s_valid,
   input  axis_mux_pkg::axis_beat_t s_beat,
   output logic                     s_ready,
   output logic                     m_valid,
   output axis_mux_pkg::axis_beat_t m_beat,
   input  logic                     m_ready
);
   import axis_mux_pkg::*;

   logic       main_valid;
   logic       skid_valid;
   axis_beat_t main_beat;
   axis_beat_t skid_beat;
   logic       main_valid_d;
   logic       skid_valid_d;
   logic       s_fire;
   logic       main_load;

   assign s_fire    = s_valid & s_ready;
   // Main entry takes a beat when empty or draining
   assign main_load = ~main_valid | m_ready;

   // ---------------------------------------
   // Occupancy
   // ---------------------------------------
   always_comb begin
      if (main_load) begin
         // Skid entry drains first, s_ready is low while it is full
         main_valid_d = skid_valid | s_fire;
         skid_valid_d = 1'b0;
      end else begin
         main_valid_d = 1'b1;
         skid_valid_d = skid_valid | s_fire;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         main_valid <= 1'b0;
         skid_valid <= 1'b0;
         s_ready    <= 1'b0;
      end else begin
         main_valid <= main_valid_d;
         skid_valid <= skid_valid_d;
         s_ready    <= ~skid_valid_d;
      end
   end

   // ---------------------------------------
   // Payload
   // ---------------------------------------
   always_ff @(posedge clk) begin
      if (main_load) begin
         main_beat <= skid_valid ? skid_beat : s_beat;
      end
      // Stalled main entry, park the incoming beat
      if (!main_load && s_fire) begin
         skid_beat <= s_beat;
      end
   end

   assign m_valid = main_valid;
   assign m_beat  = main_beat;

   a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
      m_valid && !m_ready |=> m_valid && $stable(m_beat));

endmodule

`default_nettype wire

// ==== rtl/fair_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

// ---------------------------------------
// Round-robin arbiter with packet lock
// Holds the grant until the requester
// drops hold, then rotates the pointer
// ---------------------------------------

module fair_arbiter #(
   parameter int num_ch = 4
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic [num_ch-1:0] req,
   input  logic [num_ch-1:0] hold,
   output logic [1:0]        grant_idx,
   output logic [num_ch-1:0] grant_1hot,
   output logic              grant_valid
);
   import axis_mux_pkg::*;

   arb_state_t state;
   arb_state_t state_d;
   logic [1:0] ptr;
   logic [1:0] ptr_d;
   logic [1:0] lock_idx;
   logic [1:0] search_idx;
   logic       found;
   logic       have_grant;

   // ---------------------------------------
   // Cyclic search from the pointer
   // ---------------------------------------
   always_comb begin
      int idx;
      found      = 1'b0;
      search_idx = ptr;
      for (int off = 0; off < num_ch; off++) begin
         idx = int'(ptr) + off;
         if (idx >= num_ch) begin
            idx = idx - num_ch;
         end
         if (!found && req[idx]) begin
            found      = 1'b1;
            search_idx = 2'(idx);
         end
      end
   end

   // Locked grant ignores the other requests
   always_comb begin
      if (state == ARB_LOCKED) begin
         grant_idx  = lock_idx;
         have_grant = 1'b1;
      end else begin
         grant_idx  = search_idx;
         have_grant = found;
      end
      grant_valid = have_grant & req[grant_idx];
      for (int i = 0; i < num_ch; i++) begin
         grant_1hot[i] = have_grant && (grant_idx == 2'(i));
      end
   end

   // ---------------------------------------
   // Lock and pointer update
   // ---------------------------------------
   always_comb begin
      state_d = state;
      ptr_d   = ptr;
      if (grant_valid) begin
         if (hold[grant_idx]) begin
            state_d = ARB_LOCKED;
         end else begin
            // Last beat leaves, next channel gets first look
            state_d = ARB_IDLE;
            ptr_d   = (grant_idx == 2'(num_ch - 1)) ? 2'd0 : grant_idx + 2'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= ARB_IDLE;
         ptr   <= 2'd0;
      end else begin
         state <= state_d;
         ptr   <= ptr_d;
      end
   end

   always_ff @(posedge clk) begin
      if (state == ARB_IDLE) begin
         lock_idx <= grant_idx;
      end
   end

   a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(grant_1hot));

   a_lock_stable: assert property (@(posedge clk) disable iff (!rst_n)
      state == ARB_LOCKED |-> grant_idx == $past(grant_idx));

endmodule

`default_nettype wire

// ==== rtl/axis_stream_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axis_mux_cfg.svh"

// ---------------------------------------
// Packet-aware stream multiplexer
// Input slices, round-robin packet lock
// and a registered output stage
// ---------------------------------------

module axis_stream_mux #(
   parameter int num_ch = `AXM_NUM_CH
) (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  logic [num_ch-1:0]                     s_valid,
   input  axis_mux_pkg::axis_beat_t [num_ch-1:0] s_beat,
   output logic [num_ch-1:0]                     s_ready,
   output logic                                  m_valid,
   output axis_mux_pkg::axis_beat_t              m_beat,
   input  logic                                  m_ready
);
   import axis_mux_pkg::*;

   logic [num_ch-1:0]       in_valid;
   axis_beat_t [num_ch-1:0] in_beat;
   logic [num_ch-1:0]       in_ready;
   logic [num_ch-1:0]       hold;
   logic [1:0]              grant_idx;
   logic [num_ch-1:0]       grant_1hot;
   logic                    grant_valid;
   logic                    can_load;
   axis_beat_t              sel_beat;
   logic [1:0]              out_ch;
   logic [1:0]              open_ch;
   logic                    out_open;

   // ---------------------------------------
   // Input slices
   // ---------------------------------------
   for (genvar i = 0; i < num_ch; i++) begin : g_in
      axis_skid_reg u_slice (
         .clk     (clk),
         .rst_n   (rst_n),
         .s_valid (s_valid[i]),
         .s_beat  (s_beat[i]),
         .s_ready (s_ready[i]),
         .m_valid (in_valid[i]),
         .m_beat  (in_beat[i]),
         .m_ready (in_ready[i])
      );
   end

   // ---------------------------------------
   // Arbitration
   // ---------------------------------------
   assign can_load = ~m_valid | m_ready;

   always_comb begin
      for (int i = 0; i < num_ch; i++) begin
         hold[i]     = ~in_beat[i].last | ~can_load;
         in_ready[i] = grant_1hot[i] & can_load;
      end
   end

   fair_arbiter #(
      .num_ch (num_ch)
   ) u_arb (
      .clk         (clk),
      .rst_n       (rst_n),
      .req         (in_valid),
      .hold        (hold),
      .grant_idx   (grant_idx),
      .grant_1hot  (grant_1hot),
      .grant_valid (grant_valid)
   );

   always_comb begin
      sel_beat = in_beat[0];
      for (int i = 1; i < num_ch; i++) begin
         if (grant_1hot[i]) begin
            sel_beat = in_beat[i];
         end
      end
   end

   // ---------------------------------------
   // Output stage
   // ---------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         m_valid <= 1'b0;
      end else if (can_load) begin
         m_valid <= grant_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (can_load) begin
         m_beat <= sel_beat;
         out_ch <= grant_idx;
      end
      if (m_valid && m_ready) begin
         open_ch <= out_ch;
      end
   end

   // Open after a non-last beat leaves
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_open <= 1'b0;
      end else if (m_valid && m_ready) begin
         out_open <= ~m_beat.last;
      end
   end

   a_no_interleave: assert property (@(posedge clk) disable iff (!rst_n)
      m_valid && out_open |-> out_ch == open_ch);

endmodule

`default_nettype wire

// ==== dv/tb_axis_stream_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axis_mux_cfg.svh"

// ---------------------------------------
// Stream mux testbench
// Random packet sources, random-ready
// sink, per-channel scoreboards
// ---------------------------------------

module tb_axis_stream_mux;
   import axis_mux_pkg::*;

   localparam int NCH       = `AXM_NUM_CH;
   localparam int SEQ_W     = `AXM_DATA_W - 8;
   localparam int USER_W    = `AXM_USER_W;
   localparam int DRAIN_MAX = 2000;
   localparam int PH_RAND   = 0;
   localparam int PH_LAT    = 1;
   localparam int PH_FAIR   = 2;

   // Scoreboard entry, tagged with accept cycle and phase
   typedef struct packed {
      axis_beat_t  beat;
      logic [31:0] cyc;
      logic [1:0]  phase;
   } exp_t;

   logic                 clk;
   logic                 rst_n;
   logic [NCH-1:0]       s_valid = '0;
   axis_beat_t [NCH-1:0] s_beat = '0;
   logic [NCH-1:0]       s_ready;
   logic                 m_valid;
   axis_beat_t           m_beat;
   logic                 m_ready = 1'b0;

   exp_t             exp_q[NCH][$];
   int               pkt_left[NCH];
   int               seq[NCH];
   logic [NCH-1:0]   fired = '0;
   logic [NCH-1:0]   ch_en;
   logic             no_gaps;
   logic             rand_ready;
   logic             fair_chk;
   int               phase;
   int               fair_prev = -1;
   int               cyc = 0;
   int               errors = 0;
   int               reset_errors = 0;
   int               timeouts;
   int               beats_out = 0;
   logic             in_pkt = 1'b0;
   logic [USER_W-1:0] pkt_user = '0;
   logic             stalled = 1'b0;
   axis_beat_t       stall_beat = '0;

   axis_stream_mux #(
      .num_ch (NCH)
   ) u_dut (
      .clk     (clk),
      .rst_n   (rst_n),
      .s_valid (s_valid),
      .s_beat  (s_beat),
      .s_ready (s_ready),
      .m_valid (m_valid),
      .m_beat  (m_beat),
      .m_ready (m_ready)
   );

   always #4 clk = ~clk;

   // Output stays quiet through reset and the cycle after
   a_reset_quiet: assert property (@(posedge clk) !rst_n |=> !m_valid)
      else begin
         reset_errors++;
         $display("ERROR m_valid = %h, expected %h", $sampled(m_valid), 1'b0);
      end

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] want);
      errors++;
      $display("ERROR %s = %h, expected %h", name, got, want);
   endtask

   // Top byte names the channel, the rest counts beats
   function automatic axis_beat_t make_beat(input int ch, input int n, input logic last);
      axis_beat_t b;
      b.data = {8'(ch), SEQ_W'(n)};
      b.keep = KEEP_W'($urandom);
      b.last = last;
      b.user = USER_W'(ch);
      return b;
   endfunction

   function automatic logic idle();
      logic q;
      q = (s_valid == '0) && !m_valid;
      for (int c = 0; c < NCH; c++) begin
         if (pkt_left[c] != 0 || exp_q[c].size() != 0) begin
            q = 1'b0;
         end
      end
      return q;
   endfunction

   // ---------------------------------------
   // Scoreboard side
   // ---------------------------------------
   task automatic capture_inputs();
      exp_t e;
      for (int c = 0; c < NCH; c++) begin
         fired[c] = s_valid[c] & s_ready[c];
         if (fired[c]) begin
            e.beat  = s_beat[c];
            e.cyc   = 32'(cyc);
            e.phase = 2'(phase);
            exp_q[c].push_back(e);
         end
      end
   endtask

   task automatic check_output();
      exp_t e;
      int   ch;
      if (!fair_chk) begin
         fair_prev = -1;
      end
      if (stalled) begin
         a_stall_valid: assert (m_valid) else report_mismatch("m_valid", 64'(m_valid), 64'd1);
         a_stall_beat: assert (m_beat == stall_beat)
            else report_mismatch("m_beat", 64'(m_beat), 64'(stall_beat));
      end
      stalled    = m_valid && !m_ready;
      stall_beat = m_beat;
      if (m_valid && m_ready) begin
         beats_out++;
         ch = int'(m_beat.user);
         if (ch >= NCH || exp_q[ch].size() == 0) begin
            errors++;
            $display("Output beat %h matches no beat sent on any channel", m_beat);
         end else begin
            e = exp_q[ch].pop_front();
            a_beat: assert (m_beat == e.beat)
               else report_mismatch("m_beat", 64'(m_beat), 64'(e.beat));
            if (e.phase == 2'(PH_LAT)) begin
               a_latency: assert (cyc - int'(e.cyc) == 2)
                  else report_mismatch("latency", 64'(cyc - int'(e.cyc)), 64'd2);
            end
         end
         if (in_pkt) begin
            a_no_mix: assert (m_beat.user == pkt_user)
               else report_mismatch("m_beat.user", 64'(m_beat.user), 64'(pkt_user));
         end else begin
            pkt_user = m_beat.user;
         end
         in_pkt = !m_beat.last;
         // Completed packets must rotate through the channels
         if (m_beat.last && fair_chk) begin
            if (fair_prev >= 0) begin
               a_fair: assert (ch == (fair_prev + 1) % NCH)
                  else report_mismatch("packet channel", 64'(ch), 64'((fair_prev + 1) % NCH));
            end
            fair_prev = ch;
         end
      end
   endtask

   // ---------------------------------------
   // Stimulus side
   // ---------------------------------------
   task automatic drive_inputs();
      for (int c = 0; c < NCH; c++) begin
         if (!s_valid[c] || fired[c]) begin
            s_valid[c] = 1'b0;
            if (pkt_left[c] == 0 && ch_en[c]) begin
               pkt_left[c] = 1 + int'($urandom_range(7));
            end
            if (pkt_left[c] != 0 && (no_gaps || $urandom_range(99) < 60)) begin
               s_beat[c]  = make_beat(c, seq[c], pkt_left[c] == 1);
               s_valid[c] = 1'b1;
               seq[c]++;
               pkt_left[c]--;
            end
         end
      end
      m_ready = rand_ready ? ($urandom_range(99) < 70) : 1'b1;
   endtask

   always @(posedge clk) begin
      cyc++;
      capture_inputs();
      check_output();
      #1;
      drive_inputs();
   end

   task automatic finish_run();
      $display("Beats checked: %0d, errors: %0d, reset errors: %0d, timeouts: %0d",
               beats_out, errors, reset_errors, timeouts);
      if (errors == 0 && reset_errors == 0 && timeouts == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   endtask

   task automatic wait_ready();
      int n;
      n = 0;
      while (s_ready != '1 && n < 2) begin
         @(negedge clk);
         n++;
      end
      if (s_ready != '1) begin
         timeouts++;
         $display("Timeout waiting for s_ready on every channel after reset");
      end
   endtask

   task automatic drain(input string what);
      int n;
      n = 0;
      while (!idle() && n < DRAIN_MAX) begin
         @(negedge clk);
         n++;
      end
      if (!idle()) begin
         timeouts++;
         $display("Timeout draining the %s phase, beats are stuck or lost", what);
      end
   endtask

   task automatic run_phase(input int ph, input logic [NCH-1:0] en, input logic gapless,
                            input logic rnd_rdy, input int cycles);
      @(negedge clk);
      phase      = ph;
      no_gaps    = gapless;
      rand_ready = rnd_rdy;
      fair_chk   = (ph == PH_FAIR);
      ch_en      = en;
      repeat (cycles) @(negedge clk);
      // Sources finish their open packets, then go quiet
      ch_en    = '0;
      fair_chk = 1'b0;
   endtask

   initial begin
      void'($urandom(32'h878c784e));
      clk        = 1'b0;
      rst_n      = 1'b0;
      ch_en      = '0;
      no_gaps    = 1'b0;
      rand_ready = 1'b0;
      fair_chk   = 1'b0;
      phase      = PH_RAND;
      timeouts   = 0;
      for (int c = 0; c < NCH; c++) begin
         pkt_left[c] = 0;
         seq[c]      = 0;
      end
      repeat (10) @(posedge clk);
      #1 rst_n = 1'b1;
      wait_ready();
      if (timeouts == 0) begin
         // Channel 0 alone into an open sink
         run_phase(PH_LAT, NCH'(1), 1'b0, 1'b0, 200);
         drain("latency");
      end
      if (timeouts == 0) begin
         // Every channel busy, sink always ready
         run_phase(PH_FAIR, '1, 1'b1, 1'b0, 400);
         drain("fairness");
      end
      if (timeouts == 0) begin
         // Random gaps and back-pressure
         run_phase(PH_RAND, '1, 1'b0, 1'b1, 3000);
         drain("random");
      end
      finish_run();
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+rtl
rtl/axis_mux_pkg.sv
rtl/axis_skid_reg.sv
rtl/fair_arbiter.sv
rtl/axis_stream_mux.sv
dv/tb_axis_stream_mux.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= tb_axis_stream_mux
FILELIST  ?= vlog.f
PASS_MSG  := Everything OK

.PHONY: sim clean

# Build and run, the status comes from the search for the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
